//--- tag_pkg.sv
package tag_pkg;

    // physical register file has 64 entries
    localparam int PTAG_W = 6;
    localparam int AREG_W = 5;
    localparam int ROB_W  = 6;

    // result broadcasts seen by the station, alu first then mul
    localparam int NUM_CDB = 2;

    typedef logic [PTAG_W-1:0] ptag_t;    // physical register tag
    typedef logic [AREG_W-1:0] areg_t;    // architectural register number
    typedef logic [ROB_W-1:0]  rob_idx_t; // reorder buffer slot

endpackage

//--- rs_pkg.sv
package rs_pkg;

    import tag_pkg::*;

    // which station an instruction goes to
    typedef enum logic [0:0] {
        CLASS_ALU = 1'b0,
        CLASS_MUL = 1'b1
    } rs_class_e;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLT  = 4'h5,
        OP_MUL  = 4'h8,
        OP_MULH = 4'h9  // upper half of the product
    } fu_op_e;

    // one station slot, busy means the slot holds a live instruction
    typedef struct packed {
        logic     busy;
        ptag_t    ps1;
        logic     ps1_v;   // source 1 value available
        ptag_t    ps2;
        logic     ps2_v;
        ptag_t    pd;
        areg_t    rd;
        rob_idx_t rob_entry;
        fu_op_e   op;
    } rs_entry_t;

    localparam int ALU_DEPTH = 8;
    localparam int MUL_DEPTH = 4;

endpackage

//--- cdb_if.sv
`timescale 1ns/1ps

// result broadcasts from the two functional units
interface cdb_if;

    import tag_pkg::*;

    logic  alu_valid;  // single cycle strobe
    ptag_t alu_tag;
    logic  mul_valid;
    ptag_t mul_tag;

    // everything in the station only listens
    modport sink (
        input alu_valid,
        input alu_tag,
        input mul_valid,
        input mul_tag
    );

endinterface

//--- issue_if.sv
`timescale 1ns/1ps

// one issue port from a selector towards a functional unit
interface issue_if;

    import tag_pkg::*;
    import rs_pkg::*;

    logic     valid;
    logic     fu_busy;   // level from the unit, blocks issue
    ptag_t    ps1;
    ptag_t    ps2;
    ptag_t    pd;
    areg_t    rd;
    rob_idx_t rob_entry;
    fu_op_e   op;

    modport source (
        output valid,
        input  fu_busy,
        output ps1,
        output ps2,
        output pd,
        output rd,
        output rob_entry,
        output op
    );

    modport sink (
        input  valid,
        output fu_busy,
        input  ps1,
        input  ps2,
        input  pd,
        input  rd,
        input  rob_entry,
        input  op
    );

endinterface

//--- rs_dispatch_ctrl.sv
`timescale 1ns/1ps

module rs_dispatch_ctrl (
    input  logic                dispatch_valid,
    input  rs_pkg::rs_class_e   dispatch_class,
    input  tag_pkg::ptag_t      ps1,
    input  tag_pkg::ptag_t      ps2,
    input  tag_pkg::ptag_t      pd,
    input  logic                ps1_ready,
    input  logic                ps2_ready,
    input  tag_pkg::areg_t      rd,
    input  tag_pkg::rob_idx_t   rob_entry,
    input  rs_pkg::fu_op_e      op,
    cdb_if.sink                 cdb,
    input  logic                alu_full,
    input  logic                mul_full,
    output logic                alu_write,
    output logic                mul_write,
    output rs_pkg::rs_entry_t   write_entry
);

    import tag_pkg::*;
    import rs_pkg::*;

    logic [NUM_CDB-1:0] bc_valid;
    ptag_t              bc_tag [NUM_CDB];
    logic               ps1_hit;
    logic               ps2_hit;

    always_comb
    begin
        bc_valid  = {cdb.mul_valid, cdb.alu_valid};
        bc_tag[0] = cdb.alu_tag;
        bc_tag[1] = cdb.mul_tag;
    end

    // bypass: a result on the bus this cycle counts as ready
    always_comb
    begin
        ps1_hit = 1'b0;
        ps2_hit = 1'b0;
        for (int k = 0; k < NUM_CDB; k++)
        begin
            if (bc_valid[k] && (bc_tag[k] == ps1))
            begin
                ps1_hit = 1'b1;
            end
            if (bc_valid[k] && (bc_tag[k] == ps2))
            begin
                ps2_hit = 1'b1;
            end
        end
    end

    // a dispatch into a full class is silently dropped
    assign alu_write = dispatch_valid && (dispatch_class == CLASS_ALU) && !alu_full;
    assign mul_write = dispatch_valid && (dispatch_class == CLASS_MUL) && !mul_full;

    always_comb
    begin
        write_entry.busy      = 1'b1;
        write_entry.ps1       = ps1;
        write_entry.ps1_v     = ps1_ready || ps1_hit;
        write_entry.ps2       = ps2;
        write_entry.ps2_v     = ps2_ready || ps2_hit;
        write_entry.pd        = pd;
        write_entry.rd        = rd;
        write_entry.rob_entry = rob_entry;
        write_entry.op        = op;
    end

endmodule

//--- rs_entry_array.sv
`timescale 1ns/1ps

module rs_entry_array #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       write,
    input  rs_pkg::rs_entry_t          write_entry,
    cdb_if.sink                        cdb,
    input  logic                       clear,
    input  logic [$clog2(DEPTH)-1:0]   clear_idx,
    output rs_pkg::rs_entry_t          entries [DEPTH],
    output logic                       full
);

    import tag_pkg::*;
    import rs_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    rs_entry_t          slot_q [DEPTH];
    logic [DEPTH-1:0]   busy;
    logic [IDX_W-1:0]   free_idx;
    logic [DEPTH-1:0]   wake1;
    logic [DEPTH-1:0]   wake2;
    logic [NUM_CDB-1:0] bc_valid;
    ptag_t              bc_tag [NUM_CDB];

    always_comb
    begin
        bc_valid  = {cdb.mul_valid, cdb.alu_valid};
        bc_tag[0] = cdb.alu_tag;
        bc_tag[1] = cdb.mul_tag;
    end

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            busy[i]    = slot_q[i].busy;
            entries[i] = slot_q[i];
        end
    end

    // lowest free slot, walk down so index 0 wins
    always_comb
    begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign full = &busy;

    // tag match against the current broadcasts
    always_comb
    begin
        wake1 = '0;
        wake2 = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            for (int k = 0; k < NUM_CDB; k++)
            begin
                if (busy[i] && bc_valid[k] && (bc_tag[k] == slot_q[i].ps1))
                begin
                    wake1[i] = 1'b1;
                end
                if (busy[i] && bc_valid[k] && (bc_tag[k] == slot_q[i].ps2))
                begin
                    wake2[i] = 1'b1;
                end
            end
        end
    end

    // write and clear never hit the same slot, write goes to a free one
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                slot_q[i].busy <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                if (wake1[i])
                begin
                    slot_q[i].ps1_v <= 1'b1;
                end
                if (wake2[i])
                begin
                    slot_q[i].ps2_v <= 1'b1;
                end
            end
            if (write)
            begin
                slot_q[free_idx] <= write_entry;
            end
            if (clear)
            begin
                slot_q[clear_idx].busy <= 1'b0;
            end
        end
    end

endmodule

//--- rs_issue_select.sv
`timescale 1ns/1ps

module rs_issue_select #(
    parameter int DEPTH = 4
) (
    input  rs_pkg::rs_entry_t          entries [DEPTH],
    issue_if.source                    iss,
    output logic                       clear,
    output logic [$clog2(DEPTH)-1:0]   clear_idx
);

    import rs_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic             found;
    logic [IDX_W-1:0] pick_idx;
    rs_entry_t        pick;

    // oldest position first, lowest ready index wins
    always_comb
    begin
        found    = 1'b0;
        pick_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (entries[i].busy && entries[i].ps1_v && entries[i].ps2_v)
            begin
                found    = 1'b1;
                pick_idx = IDX_W'(i);
            end
        end
    end

    assign pick = entries[pick_idx];

    assign iss.valid = found && !iss.fu_busy;
    assign clear     = iss.valid;   // slot freed at the next edge
    assign clear_idx = pick_idx;

    always_comb
    begin
        if (iss.valid)
        begin
            iss.ps1       = pick.ps1;
            iss.ps2       = pick.ps2;
            iss.pd        = pick.pd;
            iss.rd        = pick.rd;
            iss.rob_entry = pick.rob_entry;
            iss.op        = pick.op;
        end
        else
        begin
            iss.ps1       = '0;
            iss.ps2       = '0;
            iss.pd        = '0;
            iss.rd        = '0;
            iss.rob_entry = '0;
            iss.op        = OP_ADD;  // encodes as zero
        end
    end

endmodule

//--- reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  rs_pkg::rs_class_e   dispatch_class,
    input  tag_pkg::ptag_t      ps1,
    input  tag_pkg::ptag_t      ps2,
    input  logic                ps1_ready,
    input  logic                ps2_ready,
    input  tag_pkg::ptag_t      pd,
    input  tag_pkg::areg_t      rd,
    input  tag_pkg::rob_idx_t   rob_entry,
    input  rs_pkg::fu_op_e      op,
    input  logic                cdb_alu_valid,
    input  logic                cdb_mul_valid,
    input  tag_pkg::ptag_t      cdb_alu_tag,
    input  tag_pkg::ptag_t      cdb_mul_tag,
    input  logic                alu_fu_busy,
    input  logic                mul_fu_busy,
    output logic                alu_full,
    output logic                mul_full,
    output logic                alu_issue_valid,
    output tag_pkg::ptag_t      alu_issue_ps1,
    output tag_pkg::ptag_t      alu_issue_ps2,
    output tag_pkg::ptag_t      alu_issue_pd,
    output tag_pkg::areg_t      alu_issue_rd,
    output tag_pkg::rob_idx_t   alu_issue_rob_entry,
    output rs_pkg::fu_op_e      alu_issue_op,
    output logic                mul_issue_valid,
    output tag_pkg::ptag_t      mul_issue_ps1,
    output tag_pkg::ptag_t      mul_issue_ps2,
    output tag_pkg::ptag_t      mul_issue_pd,
    output tag_pkg::areg_t      mul_issue_rd,
    output tag_pkg::rob_idx_t   mul_issue_rob_entry,
    output rs_pkg::fu_op_e      mul_issue_op
);

    import rs_pkg::*;

    cdb_if   cdb ();
    issue_if alu_iss ();
    issue_if mul_iss ();

    rs_entry_t                      write_entry;
    logic                           alu_write;
    logic                           mul_write;
    rs_entry_t                      alu_entries [ALU_DEPTH];
    rs_entry_t                      mul_entries [MUL_DEPTH];
    logic                           alu_clear;
    logic                           mul_clear;
    logic [$clog2(ALU_DEPTH)-1:0]   alu_clear_idx;
    logic [$clog2(MUL_DEPTH)-1:0]   mul_clear_idx;

    assign cdb.alu_valid = cdb_alu_valid;
    assign cdb.alu_tag   = cdb_alu_tag;
    assign cdb.mul_valid = cdb_mul_valid;
    assign cdb.mul_tag   = cdb_mul_tag;

    rs_dispatch_ctrl u_dispatch_ctrl (
        .dispatch_valid (dispatch_valid),
        .dispatch_class (dispatch_class),
        .ps1            (ps1),
        .ps2            (ps2),
        .pd             (pd),
        .ps1_ready      (ps1_ready),
        .ps2_ready      (ps2_ready),
        .rd             (rd),
        .rob_entry      (rob_entry),
        .op             (op),
        .cdb            (cdb),
        .alu_full       (alu_full),
        .mul_full       (mul_full),
        .alu_write      (alu_write),
        .mul_write      (mul_write),
        .write_entry    (write_entry)
    );

    rs_entry_array #(.DEPTH(ALU_DEPTH)) u_alu_array (
        .clk         (clk),
        .rst         (rst),
        .write       (alu_write),
        .write_entry (write_entry),
        .cdb         (cdb),
        .clear       (alu_clear),
        .clear_idx   (alu_clear_idx),
        .entries     (alu_entries),
        .full        (alu_full)
    );

    rs_entry_array #(.DEPTH(MUL_DEPTH)) u_mul_array (
        .clk         (clk),
        .rst         (rst),
        .write       (mul_write),
        .write_entry (write_entry),
        .cdb         (cdb),
        .clear       (mul_clear),
        .clear_idx   (mul_clear_idx),
        .entries     (mul_entries),
        .full        (mul_full)
    );

    rs_issue_select #(.DEPTH(ALU_DEPTH)) u_alu_select (
        .entries   (alu_entries),
        .iss       (alu_iss),
        .clear     (alu_clear),
        .clear_idx (alu_clear_idx)
    );

    rs_issue_select #(.DEPTH(MUL_DEPTH)) u_mul_select (
        .entries   (mul_entries),
        .iss       (mul_iss),
        .clear     (mul_clear),
        .clear_idx (mul_clear_idx)
    );

    // alu issue port out to the pins
    assign alu_iss.fu_busy     = alu_fu_busy;
    assign alu_issue_valid     = alu_iss.valid;
    assign alu_issue_ps1       = alu_iss.ps1;
    assign alu_issue_ps2       = alu_iss.ps2;
    assign alu_issue_pd        = alu_iss.pd;
    assign alu_issue_rd        = alu_iss.rd;
    assign alu_issue_rob_entry = alu_iss.rob_entry;
    assign alu_issue_op        = alu_iss.op;

    assign mul_iss.fu_busy     = mul_fu_busy;
    assign mul_issue_valid     = mul_iss.valid;
    assign mul_issue_ps1       = mul_iss.ps1;
    assign mul_issue_ps2       = mul_iss.ps2;
    assign mul_issue_pd        = mul_iss.pd;
    assign mul_issue_rd        = mul_iss.rd;
    assign mul_issue_rob_entry = mul_iss.rob_entry;
    assign mul_issue_op        = mul_iss.op;

endmodule

//--- tb_reservation_station.sv
`timescale 1ns/1ps

module tb_reservation_station;

    import tag_pkg::*;
    import rs_pkg::*;

    // the tests take well under 120 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 400;
    localparam int unsigned SEED = 32'h6f68_70fc;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    rs_class_e dispatch_class;
    ptag_t     ps1;
    ptag_t     ps2;
    logic      ps1_ready;
    logic      ps2_ready;
    ptag_t     pd;
    areg_t     rd;
    rob_idx_t  rob_entry;
    fu_op_e    op;
    logic      cdb_alu_valid;
    logic      cdb_mul_valid;
    ptag_t     cdb_alu_tag;
    ptag_t     cdb_mul_tag;
    logic      alu_fu_busy;
    logic      mul_fu_busy;
    logic      alu_full;
    logic      mul_full;
    logic      alu_issue_valid;
    ptag_t     alu_issue_ps1;
    ptag_t     alu_issue_ps2;
    ptag_t     alu_issue_pd;
    areg_t     alu_issue_rd;
    rob_idx_t  alu_issue_rob_entry;
    fu_op_e    alu_issue_op;
    logic      mul_issue_valid;
    ptag_t     mul_issue_ps1;
    ptag_t     mul_issue_ps2;
    ptag_t     mul_issue_pd;
    areg_t     mul_issue_rd;
    rob_idx_t  mul_issue_rob_entry;
    fu_op_e    mul_issue_op;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    reservation_station u_reservation_station (
        .clk                 (clk),
        .rst                 (rst),
        .dispatch_valid      (dispatch_valid),
        .dispatch_class      (dispatch_class),
        .ps1                 (ps1),
        .ps2                 (ps2),
        .ps1_ready           (ps1_ready),
        .ps2_ready           (ps2_ready),
        .pd                  (pd),
        .rd                  (rd),
        .rob_entry           (rob_entry),
        .op                  (op),
        .cdb_alu_valid       (cdb_alu_valid),
        .cdb_mul_valid       (cdb_mul_valid),
        .cdb_alu_tag         (cdb_alu_tag),
        .cdb_mul_tag         (cdb_mul_tag),
        .alu_fu_busy         (alu_fu_busy),
        .mul_fu_busy         (mul_fu_busy),
        .alu_full            (alu_full),
        .mul_full            (mul_full),
        .alu_issue_valid     (alu_issue_valid),
        .alu_issue_ps1       (alu_issue_ps1),
        .alu_issue_ps2       (alu_issue_ps2),
        .alu_issue_pd        (alu_issue_pd),
        .alu_issue_rd        (alu_issue_rd),
        .alu_issue_rob_entry (alu_issue_rob_entry),
        .alu_issue_op        (alu_issue_op),
        .mul_issue_valid     (mul_issue_valid),
        .mul_issue_ps1       (mul_issue_ps1),
        .mul_issue_ps2       (mul_issue_ps2),
        .mul_issue_pd        (mul_issue_pd),
        .mul_issue_rd        (mul_issue_rd),
        .mul_issue_rob_entry (mul_issue_rob_entry),
        .mul_issue_op        (mul_issue_op)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // next drive point, 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // outputs are sampled mid cycle where they are settled
    task automatic mid_cycle();
        @(negedge clk);
    endtask

    function automatic ptag_t rand_tag();
        return ptag_t'($urandom());
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input ptag_t got, input ptag_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_areg(input string name, input areg_t got, input areg_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input fu_op_e got, input fu_op_e exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // one issue port must show exactly this instruction
    task automatic check_issue(input rs_class_e cls, input ptag_t s1, input ptag_t s2,
                               input ptag_t d, input areg_t r, input rob_idx_t rob,
                               input fu_op_e o);
        if (cls == CLASS_MUL)
        begin
            check_bit("mul_issue_valid", mul_issue_valid, 1'b1);
            check_tag("mul_issue_ps1", mul_issue_ps1, s1);
            check_tag("mul_issue_ps2", mul_issue_ps2, s2);
            check_tag("mul_issue_pd", mul_issue_pd, d);
            check_areg("mul_issue_rd", mul_issue_rd, r);
            check_rob("mul_issue_rob_entry", mul_issue_rob_entry, rob);
            check_op("mul_issue_op", mul_issue_op, o);
        end
        else
        begin
            check_bit("alu_issue_valid", alu_issue_valid, 1'b1);
            check_tag("alu_issue_ps1", alu_issue_ps1, s1);
            check_tag("alu_issue_ps2", alu_issue_ps2, s2);
            check_tag("alu_issue_pd", alu_issue_pd, d);
            check_areg("alu_issue_rd", alu_issue_rd, r);
            check_rob("alu_issue_rob_entry", alu_issue_rob_entry, rob);
            check_op("alu_issue_op", alu_issue_op, o);
        end
    endtask

    // called at a drive point, returns at the next one
    task automatic dispatch_one(input rs_class_e cls, input ptag_t s1, input logic r1,
                                input ptag_t s2, input logic r2, input ptag_t d,
                                input areg_t r, input rob_idx_t rob, input fu_op_e o);
        dispatch_valid = 1'b1;
        dispatch_class = cls;
        ps1            = s1;
        ps1_ready      = r1;
        ps2            = s2;
        ps2_ready      = r2;
        pd             = d;
        rd             = r;
        rob_entry      = rob;
        op             = o;
        step();
        dispatch_valid = 1'b0;
    endtask

    // single cycle result strobe from one unit
    task automatic broadcast(input rs_class_e unit, input ptag_t tag);
        if (unit == CLASS_MUL)
        begin
            cdb_mul_valid = 1'b1;
            cdb_mul_tag   = tag;
        end
        else
        begin
            cdb_alu_valid = 1'b1;
            cdb_alu_tag   = tag;
        end
        step();
        cdb_alu_valid = 1'b0;
        cdb_mul_valid = 1'b0;
    endtask

    task automatic test_reset();
        mid_cycle();
        check_bit("alu_full", alu_full, 1'b0);
        check_bit("mul_full", mul_full, 1'b0);
        check_bit("alu_issue_valid", alu_issue_valid, 1'b0);
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
    endtask

    task automatic test_ready_dispatch();
        ptag_t    s1;
        ptag_t    s2;
        ptag_t    d;
        areg_t    r;
        rob_idx_t rob;
        s1  = rand_tag();
        s2  = rand_tag();
        d   = rand_tag();
        r   = areg_t'($urandom());
        rob = rob_idx_t'($urandom());
        step();
        dispatch_one(CLASS_ALU, s1, 1'b1, s2, 1'b1, d, r, rob, OP_SUB);
        mid_cycle();
        check_issue(CLASS_ALU, s1, s2, d, r, rob, OP_SUB);
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
        step();
        mid_cycle();
        check_bit("alu_issue_valid", alu_issue_valid, 1'b0);  // slot released
    endtask

    task automatic test_wakeup();
        ptag_t    s1;
        ptag_t    w;
        ptag_t    d;
        areg_t    r;
        rob_idx_t rob;
        s1  = rand_tag();
        w   = rand_tag();
        d   = rand_tag();
        r   = areg_t'($urandom());
        rob = rob_idx_t'($urandom());
        step();
        dispatch_one(CLASS_MUL, s1, 1'b1, w, 1'b0, d, r, rob, OP_MUL);
        cdb_alu_tag = w;  // matching tag with its strobe low
        mid_cycle();
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
        step();
        broadcast(CLASS_MUL, w ^ 6'h01);  // near miss must not wake it
        mid_cycle();
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
        step();
        broadcast(CLASS_MUL, w);
        mid_cycle();
        check_issue(CLASS_MUL, s1, w, d, r, rob, OP_MUL);
        step();
        mid_cycle();
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
    endtask

    task automatic test_bypass();
        ptag_t    t;
        ptag_t    s2;
        ptag_t    d;
        areg_t    r;
        rob_idx_t rob;
        t   = rand_tag();
        s2  = rand_tag();
        d   = rand_tag();
        r   = areg_t'($urandom());
        rob = rob_idx_t'($urandom());
        step();
        cdb_alu_valid = 1'b1;
        cdb_alu_tag   = t;
        dispatch_one(CLASS_ALU, t, 1'b0, s2, 1'b1, d, r, rob, OP_XOR);
        cdb_alu_valid = 1'b0;
        mid_cycle();
        check_issue(CLASS_ALU, t, s2, d, r, rob, OP_XOR);
        step();
        mid_cycle();
        check_bit("alu_issue_valid", alu_issue_valid, 1'b0);
    endtask

    task automatic test_full_drop();
        ptag_t    s1 [5];
        ptag_t    s2 [5];
        ptag_t    d [5];
        areg_t    r [5];
        rob_idx_t rob [5];
        fu_op_e   o [5];
        rob_idx_t base;
        base = rob_idx_t'($urandom());
        for (int i = 0; i < 5; i++)
        begin
            s1[i]  = rand_tag();
            s2[i]  = rand_tag();
            d[i]   = rand_tag();
            r[i]   = areg_t'($urandom());
            rob[i] = base + rob_idx_t'(i);  // distinct ids, last one is dropped
            o[i]   = (i % 2 == 0) ? OP_MUL : OP_MULH;
        end
        step();
        mul_fu_busy = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            dispatch_one(CLASS_MUL, s1[i], 1'b1, s2[i], 1'b1, d[i], r[i], rob[i], o[i]);
            mid_cycle();
            check_bit("mul_full", mul_full, i == 3);
            check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
            step();
        end
        dispatch_one(CLASS_MUL, s1[4], 1'b1, s2[4], 1'b1, d[4], r[4], rob[4], o[4]);
        mid_cycle();
        check_bit("mul_full", mul_full, 1'b1);
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
        step();
        mul_fu_busy = 1'b0;
        // drains lowest index first, one per cycle
        for (int i = 0; i < 4; i++)
        begin
            mid_cycle();
            check_issue(CLASS_MUL, s1[i], s2[i], d[i], r[i], rob[i], o[i]);
            check_bit("mul_full", mul_full, i == 0);
            step();
        end
        mid_cycle();
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
    endtask

    task automatic test_back_pressure();
        ptag_t    a1;
        ptag_t    a2;
        ptag_t    ad;
        areg_t    ar;
        rob_idx_t arob;
        ptag_t    m1;
        ptag_t    m2;
        ptag_t    md;
        areg_t    mr;
        rob_idx_t mrob;
        a1   = rand_tag();
        a2   = rand_tag();
        ad   = rand_tag();
        ar   = areg_t'($urandom());
        arob = rob_idx_t'($urandom());
        m1   = rand_tag();
        m2   = rand_tag();
        md   = rand_tag();
        mr   = areg_t'($urandom());
        mrob = rob_idx_t'($urandom());
        step();
        alu_fu_busy = 1'b1;
        dispatch_one(CLASS_ALU, a1, 1'b1, a2, 1'b1, ad, ar, arob, OP_AND);
        mid_cycle();
        check_bit("alu_issue_valid", alu_issue_valid, 1'b0);
        step();
        dispatch_one(CLASS_MUL, m1, 1'b1, m2, 1'b1, md, mr, mrob, OP_MULH);
        mid_cycle();
        check_issue(CLASS_MUL, m1, m2, md, mr, mrob, OP_MULH);
        check_bit("alu_issue_valid", alu_issue_valid, 1'b0);
        step();
        alu_fu_busy = 1'b0;
        mid_cycle();
        check_issue(CLASS_ALU, a1, a2, ad, ar, arob, OP_AND);
        check_bit("mul_issue_valid", mul_issue_valid, 1'b0);
        step();
        mid_cycle();
        check_bit("alu_issue_valid", alu_issue_valid, 1'b0);
    endtask

    initial
    begin
        void'($urandom(SEED));
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_class = CLASS_ALU;
        ps1            = '0;
        ps2            = '0;
        ps1_ready      = 1'b0;
        ps2_ready      = 1'b0;
        pd             = '0;
        rd             = '0;
        rob_entry      = '0;
        op             = OP_ADD;
        cdb_alu_valid  = 1'b0;
        cdb_mul_valid  = 1'b0;
        cdb_alu_tag    = '0;
        cdb_mul_tag    = '0;
        alu_fu_busy    = 1'b0;
        mul_fu_busy    = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_ready_dispatch();
        test_wakeup();
        test_bypass();
        test_full_drop();
        test_back_pressure();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- reservation_station.f
tag_pkg.sv
rs_pkg.sv
cdb_if.sv
issue_if.sv
rs_dispatch_ctrl.sv
rs_entry_array.sv
rs_issue_select.sv
reservation_station.sv
tb_reservation_station.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the reservation station testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f reservation_station.f \
    --top-module tb_reservation_station -o sim_rs
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_rs)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
